// File: vlog.f
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_latch.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/decode_stage.sv
test/tb_clock.sv
test/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module decode_stage_tb -f vlog.f -o decode_stage_sim \
    && ./obj_dir/decode_stage_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

// File: test/decode_stage_tb.sv
// Decode stage testbench
`timescale 1ns/1ps

module decode_stage_tb;

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int TIMEOUT_NS      = (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD;
    localparam logic [31:0] SEED   = 32'hf78e;

    logic        clk;
    logic        reset;
    logic        fs_valid;
    fetch_bus_t  fs_bus;
    logic        ds_allowin;
    logic        ds_to_es_valid;
    decode_bus_t ds_to_es_bus;
    logic        es_allowin;
    wb_bus_t     wb_bus;
    es_fwd_bus_t es_fwd;
    fwd_bus_t    ms_fwd;
    fwd_bus_t    ws_fwd;
    br_bus_t     br_bus;
    logic        stop;

    // Reference copy of the register file
    xlen_t       rf_model [REG_NUM];
    string       test_name;
    int          errors;
    int          checks;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock0 (
        .clk   (clk),
        .reset (reset)
    );

    decode_stage dut0 (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fs_bus         (fs_bus),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .wb_bus         (wb_bus),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .br_bus         (br_bus),
        .stop           (stop)
    );

    // ------------------------------------------------------------------
    // Helpers
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string what, input xlen_t expected, input xlen_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s %s: expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    function automatic xlen_t sext(input int value);
        return xlen_t'(longint'(value));
    endfunction

    function automatic xlen_t model_read(input reg_addr_t addr);
        return (addr == '0) ? '0 : rf_model[addr];
    endfunction

    function automatic fwd_bus_t make_fwd(input logic valid, input reg_addr_t dest,
                                          input xlen_t data);
        fwd_bus_t bus;
        bus.valid = valid;
        bus.dest  = dest;
        bus.data  = data;
        return bus;
    endfunction

    // Instruction formats
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3,
                                          input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                          input logic [2:0] f3, input reg_addr_t rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic clear_fwd();
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input xlen_t data);
        wb_bus.we   = 1'b1;
        wb_bus.addr = addr;
        wb_bus.data = data;
        step();
        wb_bus.we = 1'b0;
        if (addr != '0) begin
            rf_model[addr] = data;
        end
    endtask

    // Offer one instruction and return just after the transfer edge
    task automatic send(input logic [31:0] inst, input xlen_t pc);
        logic accepted;
        accepted    = 1'b0;
        fs_valid    = 1'b1;
        fs_bus.inst = inst;
        fs_bus.pc   = pc;
        while (!accepted) begin
            #1;
            accepted = ds_allowin;
            step();
        end
        fs_valid = 1'b0;
    endtask

    task automatic drain();
        es_allowin = 1'b1;
        fs_valid   = 1'b0;
        clear_fwd();
        step();
        step();
    endtask

    // ------------------------------------------------------------------
    // Tests
    task automatic test_reg_read();
        test_name = "reg_read";
        for (int r = 0; r < REG_NUM; r++) begin
            write_reg(reg_addr_t'(r), {$urandom, $urandom});
        end
        send(enc_r(F7_NORMAL, 5'd7, 5'd3, F3_ADD, 5'd5, OPC_OP), 64'h1000);
        check_bit("add valid", 1'b1, ds_to_es_valid);
        check_val("add rs1", model_read(5'd3), ds_to_es_bus.rs1_value);
        check_val("add rs2", model_read(5'd7), ds_to_es_bus.rs2_value);
        check_val("add alu_op", xlen_t'(ALU_ADD), xlen_t'(ds_to_es_bus.ctrl.alu_op));
        check_val("add rd", xlen_t'(5'd5), xlen_t'(ds_to_es_bus.ctrl.rd));
        check_val("add pc", 64'h1000, ds_to_es_bus.pc);
        check_bit("add rf_we", 1'b1, ds_to_es_bus.ctrl.rf_we);
        send(enc_r(F7_ALT, 5'd12, 5'd0, F3_ADD, 5'd9, OPC_OP), 64'h1004);
        check_val("sub x0", '0, ds_to_es_bus.rs1_value);
        check_val("sub rs2", model_read(5'd12), ds_to_es_bus.rs2_value);
        check_val("sub alu_op", xlen_t'(ALU_SUB), xlen_t'(ds_to_es_bus.ctrl.alu_op));
        send(enc_i(12'(-5), 5'd4, F3_ADD, 5'd10, OPC_OP_IMM), 64'h1008);
        check_val("addi rs1", model_read(5'd4), ds_to_es_bus.rs1_value);
        check_val("addi imm", sext(-5), ds_to_es_bus.imm);
        check_val("addi rd", xlen_t'(5'd10), xlen_t'(ds_to_es_bus.ctrl.rd));
        check_val("addi alu_op", xlen_t'(ALU_ADD), xlen_t'(ds_to_es_bus.ctrl.alu_op));
        check_val("addi src2", xlen_t'(SRC2_IMM_I), xlen_t'(ds_to_es_bus.ctrl.src_sel.src2));
        drain();
    endtask

    task automatic test_forwarding();
        xlen_t es_data;
        xlen_t ms_data;
        xlen_t ws_data;
        test_name = "forwarding";
        es_data = {$urandom, $urandom};
        ms_data = {$urandom, $urandom};
        ws_data = {$urandom, $urandom};
        // Hold the item in the stage while the forward sources change
        es_allowin     = 1'b0;
        es_fwd.is_load = 1'b0;
        es_fwd.fwd     = make_fwd(1'b1, 5'd8, es_data);
        ms_fwd         = make_fwd(1'b1, 5'd8, ms_data);
        ws_fwd         = make_fwd(1'b1, 5'd8, ws_data);
        send(enc_r(F7_NORMAL, 5'd2, 5'd8, F3_ADD, 5'd6, OPC_OP), 64'h2000);
        check_val("es data", es_data, ds_to_es_bus.rs1_value);
        check_val("rs2 from file", model_read(5'd2), ds_to_es_bus.rs2_value);
        step();
        es_fwd.fwd.valid = 1'b0;
        #1;
        check_val("ms data", ms_data, ds_to_es_bus.rs1_value);
        step();
        ms_fwd.valid = 1'b0;
        #1;
        check_val("ws data", ws_data, ds_to_es_bus.rs1_value);
        step();
        ws_fwd.valid = 1'b0;
        #1;
        check_val("file data", model_read(5'd8), ds_to_es_bus.rs1_value);
        check_bit("held valid", 1'b1, ds_to_es_valid);
        drain();
        es_fwd.fwd = make_fwd(1'b1, 5'd0, es_data);
        ms_fwd     = make_fwd(1'b1, 5'd0, ms_data);
        ws_fwd     = make_fwd(1'b1, 5'd0, ws_data);
        send(enc_r(F7_NORMAL, 5'd0, 5'd0, F3_ADD, 5'd6, OPC_OP), 64'h2004);
        check_val("x0 rs1", '0, ds_to_es_bus.rs1_value);
        check_val("x0 rs2", '0, ds_to_es_bus.rs2_value);
        drain();
    endtask

    task automatic test_load_use();
        xlen_t load_data;
        test_name = "load_use";
        load_data = {$urandom, $urandom};
        // A load to another register must not stall
        es_fwd.is_load = 1'b1;
        es_fwd.fwd     = make_fwd(1'b1, 5'd20, load_data);
        send(enc_i(12'(3), 5'd11, F3_ADD, 5'd12, OPC_OP_IMM), 64'h3000);
        check_bit("other load valid", 1'b1, ds_to_es_valid);
        drain();
        es_fwd.is_load = 1'b1;
        es_fwd.fwd     = make_fwd(1'b1, 5'd11, load_data);
        send(enc_i(12'(3), 5'd11, F3_ADD, 5'd12, OPC_OP_IMM), 64'h3004);
        check_bit("stall valid", 1'b0, ds_to_es_valid);
        check_bit("stall allowin", 1'b0, ds_allowin);
        step();
        check_bit("still stalled", 1'b0, ds_to_es_valid);
        check_bit("still blocked", 1'b0, ds_allowin);
        es_fwd.is_load = 1'b0;
        #1;
        check_bit("release valid", 1'b1, ds_to_es_valid);
        check_bit("release allowin", 1'b1, ds_allowin);
        check_val("forwarded load", load_data, ds_to_es_bus.rs1_value);
        check_val("release pc", 64'h3004, ds_to_es_bus.pc);
        drain();
    endtask

    task automatic run_branch(input logic [2:0] f3, input reg_addr_t rs1,
                              input reg_addr_t rs2, input int offset, input xlen_t pc);
        xlen_t a;
        xlen_t b;
        logic  expect_taken;
        a = model_read(rs1);
        b = model_read(rs2);
        case (f3)
            F3_BEQ:  expect_taken = a == b;
            F3_BNE:  expect_taken = a != b;
            F3_BLT:  expect_taken = $signed(a) < $signed(b);
            F3_BGE:  expect_taken = $signed(a) >= $signed(b);
            F3_BLTU: expect_taken = a < b;
            default: expect_taken = a >= b;
        endcase
        send(enc_b(13'(offset), rs2, rs1, f3), pc);
        check_bit($sformatf("taken f3=%0d x%0d x%0d", f3, rs1, rs2), expect_taken,
                  br_bus.taken);
        check_val($sformatf("target f3=%0d", f3), pc + sext(offset), br_bus.target);
    endtask

    task automatic test_branches();
        logic [2:0] kinds [6];
        xlen_t      pc;
        test_name = "branches";
        kinds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        pc    = 64'h8000_1000;
        // Negative signed but large unsigned against a small positive
        write_reg(5'd13, 64'hffff_ffff_ffff_fff0);
        write_reg(5'd14, 64'h0000_0000_0000_0010);
        for (int k = 0; k < 6; k++) begin
            run_branch(kinds[k], 5'd13, 5'd14, -12, pc);
            run_branch(kinds[k], 5'd14, 5'd13, 40, pc);
            run_branch(kinds[k], 5'd14, 5'd14, 2046, pc);
        end
        send(enc_i(12'(1), 5'd13, F3_ADD, 5'd2, OPC_OP_IMM), pc);
        check_bit("addi not taken", 1'b0, br_bus.taken);
        send(enc_j(21'(-2052), 5'd1), pc);
        check_bit("jal taken", 1'b1, br_bus.taken);
        check_val("jal target", pc + sext(-2052), br_bus.target);
        check_val("jal imm", sext(-2052), ds_to_es_bus.imm);
        check_val("jal src2", xlen_t'(SRC2_CONST4), xlen_t'(ds_to_es_bus.ctrl.src_sel.src2));
        send(enc_i(12'(-8), 5'd14, F3_JALR, 5'd1, OPC_JALR), pc);
        check_bit("jalr taken", 1'b1, br_bus.taken);
        check_val("jalr target", model_read(5'd14) + sext(-8), br_bus.target);
        // Stage register still holds the JALR once empty
        drain();
        check_bit("idle not taken", 1'b0, br_bus.taken);
    endtask

    task automatic test_backpressure();
        decode_bus_t held;
        test_name = "backpressure";
        es_allowin = 1'b0;
        send(enc_i(12'(100), 5'd3, F3_ADD, 5'd15, OPC_OP_IMM), 64'h5000);
        held = ds_to_es_bus;
        step();
        fs_valid    = 1'b1;
        fs_bus.inst = enc_i(12'(7), 5'd4, F3_ADD, 5'd16, OPC_OP_IMM);
        fs_bus.pc   = 64'h5004;
        for (int k = 0; k < 4; k++) begin
            #1;
            check_bit("allowin low", 1'b0, ds_allowin);
            check_bit("valid held", 1'b1, ds_to_es_valid);
            checks++;
            if (ds_to_es_bus !== held) begin
                errors++;
                $display("Fail %s bus: expected %h, actual %h", test_name, held, ds_to_es_bus);
            end
            step();
        end
        es_allowin = 1'b1;
        #1;
        check_bit("allowin after release", 1'b1, ds_allowin);
        check_val("pc before release", 64'h5000, ds_to_es_bus.pc);
        step();
        fs_valid = 1'b0;
        check_val("next pc", 64'h5004, ds_to_es_bus.pc);
        check_val("next rd", xlen_t'(5'd16), xlen_t'(ds_to_es_bus.ctrl.rd));
        check_val("next rs1", model_read(5'd4), ds_to_es_bus.rs1_value);
        drain();
    endtask

    task automatic test_stop();
        test_name = "stop";
        send({IMM_EBREAK, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM}, 64'h6000);
        check_bit("ebreak", 1'b1, stop);
        send(enc_r(F7_NORMAL, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_OP), 64'h6004);
        check_bit("add", 1'b0, stop);
        send(32'h0000_0000, 64'h6008);
        check_bit("all zero", 1'b1, stop);
        // Unknown instruction left in the stage register
        drain();
        check_bit("idle", 1'b0, stop);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    initial begin
        errors     = 0;
        checks     = 0;
        void'($urandom(SEED));
        fs_valid   = 1'b0;
        fs_bus     = '0;
        es_allowin = 1'b1;
        wb_bus     = '0;
        clear_fwd();
        test_name = "reset";
        wait (reset == 1'b0);
        step();
        check_bit("valid", 1'b0, ds_to_es_valid);
        check_bit("taken", 1'b0, br_bus.taken);
        check_bit("stop", 1'b0, stop);
        check_bit("allowin", 1'b1, ds_allowin);
        test_reg_read();
        test_forwarding();
        test_load_use();
        test_branches();
        test_backpressure();
        test_stop();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

// File: verilog/decode_stage.sv
// Instruction decode stage
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fs_valid,
    input  pipe_pkg::fetch_bus_t   fs_bus,
    output logic                   ds_allowin,
    output logic                   ds_to_es_valid,
    output pipe_pkg::decode_bus_t  ds_to_es_bus,
    input  logic                   es_allowin,
    input  pipe_pkg::wb_bus_t      wb_bus,
    input  pipe_pkg::es_fwd_bus_t  es_fwd,
    input  pipe_pkg::fwd_bus_t     ms_fwd,
    input  pipe_pkg::fwd_bus_t     ws_fwd,
    output pipe_pkg::br_bus_t      br_bus,
    output logic                   stop
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic       ds_valid;
    logic       stall;
    fetch_bus_t ds_bus;
    ctrl_t      ctrl;
    xlen_t      imm;
    br_kind_t   br_kind;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      rf_data1;
    xlen_t      rf_data2;
    xlen_t      rs1_value;
    xlen_t      rs2_value;

    stage_latch latch0 (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fs_bus         (fs_bus),
        .es_allowin     (es_allowin),
        .stall          (stall),
        .ds_valid       (ds_valid),
        .ds_bus         (ds_bus),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid)
    );

    inst_decoder decoder0 (
        .inst    (ds_bus.inst),
        .valid   (ds_valid),
        .ctrl    (ctrl),
        .imm     (imm),
        .br_kind (br_kind),
        .rs1     (rs1),
        .rs2     (rs2),
        .stop    (stop)
    );

    reg_file rf0 (
        .clk    (clk),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .wb     (wb_bus)
    );

    operand_bypass bypass0 (
        .rs1       (rs1),
        .rs2       (rs2),
        .rf_data1  (rf_data1),
        .rf_data2  (rf_data2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_fwd    (ws_fwd),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .stall     (stall)
    );

    branch_unit branch0 (
        .valid     (ds_valid),
        .br_kind   (br_kind),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .pc        (ds_bus.pc),
        .imm       (imm),
        .br_bus    (br_bus)
    );

    // ------------------------------------------------------------------
    // Bus to execute
    assign ds_to_es_bus.ctrl      = ctrl;
    assign ds_to_es_bus.imm       = imm;
    assign ds_to_es_bus.rs1_value = rs1_value;
    assign ds_to_es_bus.rs2_value = rs2_value;
    assign ds_to_es_bus.pc        = ds_bus.pc;

endmodule

// File: verilog/branch_unit.sv
// Branch and jump resolution
`timescale 1ns/1ps

module branch_unit (
    input  logic                 valid,
    input  rv_isa_pkg::br_kind_t br_kind,
    input  rv_isa_pkg::xlen_t    rs1_value,
    input  rv_isa_pkg::xlen_t    rs2_value,
    input  rv_isa_pkg::xlen_t    pc,
    input  rv_isa_pkg::xlen_t    imm,
    output pipe_pkg::br_bus_t    br_bus
);

    import rv_isa_pkg::*;

    logic  eq;
    logic  lt;
    logic  ltu;
    logic  cond;
    xlen_t base;

    assign eq  = rs1_value == rs2_value;
    assign lt  = $signed(rs1_value) < $signed(rs2_value);
    assign ltu = rs1_value < rs2_value;

    always_comb begin
        case (br_kind)
            BR_BEQ:           cond = eq;
            BR_BNE:           cond = !eq;
            BR_BLT:           cond = lt;
            BR_BGE:           cond = !lt;
            BR_BLTU:          cond = ltu;
            BR_BGEU:          cond = !ltu;
            BR_JAL, BR_JALR:  cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    // JALR is register relative, everything else pc relative
    assign base = (br_kind == BR_JALR) ? rs1_value : pc;

    assign br_bus.taken  = valid && cond;
    assign br_bus.target = base + imm;

endmodule

// File: verilog/operand_bypass.sv
// Operand forwarding and load-use detection
`timescale 1ns/1ps

module operand_bypass (
    input  rv_isa_pkg::reg_addr_t rs1,
    input  rv_isa_pkg::reg_addr_t rs2,
    input  rv_isa_pkg::xlen_t     rf_data1,
    input  rv_isa_pkg::xlen_t     rf_data2,
    input  pipe_pkg::es_fwd_bus_t es_fwd,
    input  pipe_pkg::fwd_bus_t    ms_fwd,
    input  pipe_pkg::fwd_bus_t    ws_fwd,
    output rv_isa_pkg::xlen_t     rs1_value,
    output rv_isa_pkg::xlen_t     rs2_value,
    output logic                  stall
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic es_dest_hit;

    function automatic logic hit(input fwd_bus_t fwd, input reg_addr_t rs);
        return fwd.valid && fwd.dest == rs && rs != '0;
    endfunction

    // Youngest producer wins
    function automatic xlen_t select(input reg_addr_t rs, input xlen_t rf_data,
                                     input fwd_bus_t es, input fwd_bus_t ms,
                                     input fwd_bus_t ws);
        xlen_t value;
        if (hit(es, rs)) begin
            value = es.data;
        end else if (hit(ms, rs)) begin
            value = ms.data;
        end else if (hit(ws, rs)) begin
            value = ws.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign rs1_value = select(rs1, rf_data1, es_fwd.fwd, ms_fwd, ws_fwd);
    assign rs2_value = select(rs2, rf_data2, es_fwd.fwd, ms_fwd, ws_fwd);

    // Load data is not ready until memory stage
    assign es_dest_hit = (rs1 != '0 && es_fwd.fwd.dest == rs1) ||
                         (rs2 != '0 && es_fwd.fwd.dest == rs2);
    assign stall       = es_fwd.is_load && es_dest_hit;

endmodule

// File: verilog/reg_file.sv
// Integer register file
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  rv_isa_pkg::reg_addr_t raddr1,
    input  rv_isa_pkg::reg_addr_t raddr2,
    output rv_isa_pkg::xlen_t     rdata1,
    output rv_isa_pkg::xlen_t     rdata2,
    input  pipe_pkg::wb_bus_t     wb
);

    import rv_isa_pkg::*;

    xlen_t regs [REG_NUM];

    // Writeback port, x0 is hardwired
    always_ff @(posedge clk) begin
        if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Asynchronous reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/inst_decoder.sv
// RV64I instruction decoder
`timescale 1ns/1ps

module inst_decoder (
    input  logic [rv_isa_pkg::INST_W-1:0] inst,
    input  logic                          valid,
    output pipe_pkg::ctrl_t               ctrl,
    output rv_isa_pkg::xlen_t             imm,
    output rv_isa_pkg::br_kind_t          br_kind,
    output rv_isa_pkg::reg_addr_t         rs1,
    output rv_isa_pkg::reg_addr_t         rs2,
    output logic                          stop
);

    import rv_isa_pkg::*;

    inst_fields_t f;
    xlen_t        imm_i;
    xlen_t        imm_s;
    xlen_t        imm_b;
    xlen_t        imm_u;
    xlen_t        imm_j;
    logic         shift;
    logic         sh_ok;
    logic         legal;
    logic         ebreak;
    logic         use_rs1;
    logic         use_rs2;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt_op);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = alt_op ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt_op ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign f = inst;

    // ------------------------------------------------------------------
    // Immediates, all sign-extended
    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Shift immediates keep funct7[6:1]; the W forms also need shamt[5] clear
    assign shift = f.funct3 == F3_SLL || f.funct3 == F3_SR;
    assign sh_ok = f.funct7[6:1] == F7_NORMAL[6:1] ||
                   (f.funct7[6:1] == F7_ALT[6:1] && f.funct3 == F3_SR);

    // ------------------------------------------------------------------
    always_comb begin
        ctrl    = '0;
        ctrl.rd = f.rd;
        imm     = '0;
        br_kind = BR_NONE;
        legal   = 1'b0;
        ebreak  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (f.opcode)
            OPC_LUI, OPC_AUIPC: begin
                legal              = 1'b1;
                ctrl.rf_we         = 1'b1;
                ctrl.src_sel.is_pc = f.opcode == OPC_AUIPC;
                ctrl.src_sel.src2  = SRC2_IMM_U;
                imm                = imm_u;
            end
            OPC_JAL, OPC_JALR: begin
                // Link value is pc + 4
                legal              = f.opcode == OPC_JAL || f.funct3 == F3_JALR;
                ctrl.rf_we         = 1'b1;
                ctrl.src_sel.is_pc = 1'b1;
                ctrl.src_sel.src2  = SRC2_CONST4;
                use_rs1            = f.opcode == OPC_JALR;
                br_kind            = (f.opcode == OPC_JAL) ? BR_JAL : BR_JALR;
                imm                = (f.opcode == OPC_JAL) ? imm_j : imm_i;
            end
            OPC_BRANCH: begin
                legal   = f.funct3[2:1] != 2'b01;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = imm_b;
                case (f.funct3)
                    F3_BEQ:  br_kind = BR_BEQ;
                    F3_BNE:  br_kind = BR_BNE;
                    F3_BLT:  br_kind = BR_BLT;
                    F3_BGE:  br_kind = BR_BGE;
                    F3_BLTU: br_kind = BR_BLTU;
                    F3_BGEU: br_kind = BR_BGEU;
                    default: br_kind = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                legal             = f.funct3 != 3'b111;
                ctrl.rf_we        = 1'b1;
                ctrl.mem_re       = 1'b1;
                ctrl.mem_size     = mem_size_t'(f.funct3[1:0]);
                ctrl.res_sext     = !f.funct3[2] && f.funct3[1:0] != 2'b11;
                ctrl.res_zext     = f.funct3[2];
                ctrl.src_sel.src2 = SRC2_IMM_I;
                use_rs1           = 1'b1;
                imm               = imm_i;
            end
            OPC_STORE: begin
                legal             = !f.funct3[2];
                ctrl.mem_we       = 1'b1;
                ctrl.mem_size     = mem_size_t'(f.funct3[1:0]);
                ctrl.src_sel.src2 = SRC2_IMM_S;
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
                imm               = imm_s;
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                legal = (f.opcode == OPC_OP_IMM) ? (!shift || sh_ok)
                        : (f.funct3 == F3_ADD || (shift && sh_ok && !f.funct7[0]));
                ctrl.rf_we        = 1'b1;
                ctrl.alu_op       = alu_sel(f.funct3, shift && f.funct7[5]);
                ctrl.src_sel.src2 = shift ? SRC2_SHAMT : SRC2_IMM_I;
                ctrl.res_sext     = f.opcode == OPC_OP_IMM_32;
                use_rs1           = 1'b1;
                imm               = imm_i;
            end
            OPC_OP, OPC_OP_32: begin
                legal = (f.funct7 == F7_NORMAL ||
                         (f.funct7 == F7_ALT && (f.funct3 == F3_ADD || f.funct3 == F3_SR))) &&
                        (f.opcode == OPC_OP || f.funct3 == F3_ADD || shift);
                ctrl.rf_we    = 1'b1;
                ctrl.alu_op   = alu_sel(f.funct3, f.funct7[5]);
                ctrl.res_sext = f.opcode == OPC_OP_32;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            OPC_SYSTEM: begin
                ebreak = f.funct3 == F3_PRIV && f.rd == '0 && f.rs1 == '0 &&
                         inst[31:20] == IMM_EBREAK;
                legal  = ebreak;
            end
            default: ;
        endcase
    end

    // Unused source fields read x0, so they never hit a forward or stall
    assign rs1  = use_rs1 ? f.rs1 : '0;
    assign rs2  = use_rs2 ? f.rs2 : '0;
    assign stop = valid && (ebreak || !legal);

endmodule

// File: verilog/stage_latch.sv
// Decode stage register
`timescale 1ns/1ps

module stage_latch (
    input  logic                clk,
    input  logic                reset,
    input  logic                fs_valid,
    input  pipe_pkg::fetch_bus_t fs_bus,
    input  logic                es_allowin,
    input  logic                stall,
    output logic                ds_valid,
    output pipe_pkg::fetch_bus_t ds_bus,
    output logic                ds_allowin,
    output logic                ds_to_es_valid
);

    // Take a new item when empty or when the current one leaves
    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bus <= fs_bus;
        end
    end

endmodule

// File: verilog/pipe_pkg.sv
// Pipeline stage buses
package pipe_pkg;

    import rv_isa_pkg::*;

    // ------------------------------------------------------------------
    // Fetch and writeback
    typedef struct packed {
        logic [INST_W-1:0] inst;
        xlen_t             pc;
    } fetch_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        xlen_t     data;
    } wb_bus_t;

    // Forwarding from later stages
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        xlen_t     data;
    } fwd_bus_t;

    typedef struct packed {
        logic     is_load;
        fwd_bus_t fwd;
    } es_fwd_bus_t;

    // ------------------------------------------------------------------
    // Decode to execute
    typedef struct packed {
        alu_op_t   alu_op;
        src_sel_t  src_sel;
        logic      res_sext;
        logic      res_zext;
        logic      rf_we;
        logic      mem_we;
        logic      mem_re;
        mem_size_t mem_size;
        reg_addr_t rd;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        xlen_t imm;
        xlen_t rs1_value;
        xlen_t rs2_value;
        xlen_t pc;
    } decode_bus_t;

    // Redirect to fetch
    typedef struct packed {
        logic  taken;
        xlen_t target;
    } br_bus_t;

endpackage

// File: verilog/rv_isa_pkg.sv
// RV64I instruction set definitions
package rv_isa_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_NUM    = 32;
    localparam int REG_ADDR_W = $clog2(REG_NUM);

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]       xlen_t;

    // ------------------------------------------------------------------
    // Opcodes
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // Branch kinds
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU kinds, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0]  F3_JALR    = 3'b000;
    localparam logic [2:0]  F3_PRIV    = 3'b000;
    localparam logic [11:0] IMM_EBREAK = 12'h001;

    localparam logic [6:0] F7_NORMAL = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;

    // ------------------------------------------------------------------
    // R-type view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_fields_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    typedef enum logic [2:0] {
        SRC2_RS2, SRC2_IMM_I, SRC2_IMM_S, SRC2_IMM_U, SRC2_SHAMT, SRC2_CONST4
    } src2_t;

    typedef struct packed {
        logic  is_pc;
        src2_t src2;
    } src_sel_t;

    typedef enum logic [1:0] {MEM_B, MEM_H, MEM_W, MEM_D} mem_size_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_kind_t;

endpackage
